/* design/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// LED register, single word
`define LED_ADDR        32'hFFFF_0000

// Upper half of address selects the VGA window
`define VGA_BASE_HI     16'hAAAA

// Register offsets inside the VGA window
`define VGA_REG_FG      16'h0000
`define VGA_REG_BG      16'h0004
`define VGA_REG_CTRL    16'h0008
`define VGA_REG_STATUS  16'h000C

// Word RAM depth and word-address width
`define RAM_WORDS       1024
`define RAM_AW          10

// Default 640x480 raster timing, in pixel clocks and lines
`define H_ACTIVE        640
`define H_FRONT         16
`define H_SYNC          96
`define H_BACK          48
`define V_ACTIVE        480
`define V_FRONT         10
`define V_SYNC          2
`define V_BACK          33

// Checker cell is 2**CELL_LOG2 pixels wide
`define CELL_LOG2       3

`endif

/* design/soc_pkg.sv */
package soc_pkg;

    // Bus address and data words
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Single-cycle access from the bus master
    typedef struct packed {
        logic      we;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // One-hot region strobes
    typedef struct packed {
        logic ram;
        logic led;
        logic vga;
    } dev_sel_t;

    // One 4-bit VGA colour channel
    typedef logic [3:0] colour_t;

    // Packed pixel colour, 12 bits
    typedef struct packed {
        colour_t r;
        colour_t g;
        colour_t b;
    } rgb_t;

    // Pixel column or line number
    typedef logic [10:0] pix_pos_t;

endpackage

/* design/bus_decoder.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module bus_decoder (
    input  logic              sys_clk,
    input  logic              arst_n,
    input  soc_pkg::bus_addr_t addr,
    output soc_pkg::dev_sel_t  sel,
    input  soc_pkg::bus_data_t ram_rdata,
    input  soc_pkg::bus_data_t io_rdata,
    output soc_pkg::bus_data_t rdata
);

    // Last access went to RAM
    logic ram_q;

    // Region decode gives exactly one strobe per cycle
    always_comb begin
        sel = '0;
        if (addr == `LED_ADDR) begin
            sel.led = 1'b1;
        end else if (addr[31:16] == `VGA_BASE_HI) begin
            sel.vga = 1'b1;
        end else begin
            // Everything else is RAM
            sel.ram = 1'b1;
        end
    end

    // Remember the region so the read source lines up with
    // the registered data coming back a cycle later
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_q <= 1'b0;
        end else begin
            ram_q <= sel.ram;
        end
    end

    // Read steering
    // After reset the IO path is chosen, and it reads zero
    assign rdata = ram_q ? ram_rdata : io_rdata;

    // An unknown address would silently fall through to RAM
    // Decode must also never select zero or two devices
    a_sel_onehot: assert property (
        @(posedge sys_clk) disable iff (!arst_n)
        !$isunknown(addr) && $onehot(sel)
    );

endmodule

/* design/ram_block.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module ram_block #(
    parameter int WORDS = `RAM_WORDS
) (
    input  logic                sys_clk,
    input  logic                stb,
    input  logic                we,
    input  logic [`RAM_AW-1:0]  word_addr,
    input  soc_pkg::bus_data_t  wdata,
    output soc_pkg::bus_data_t  rdata
);

    import soc_pkg::*;

    // Storage array
    bus_data_t mem [WORDS];

    // Single port, synchronous read
    // Write-first: a write returns the new word on rdata
    always_ff @(posedge sys_clk) begin
        if (stb) begin
            if (we) begin
                mem[word_addr] <= wdata;
                rdata          <= wdata;
            end else begin
                rdata <= mem[word_addr];
            end
        end
    end

    // Word index must be clean on any selected access
    a_addr_known: assert property (
        @(posedge sys_clk)
        stb |-> !$isunknown(word_addr)
    );

endmodule

/* design/io_regs.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module io_regs (
    input  logic               sys_clk,
    input  logic               arst_n,
    input  logic               led_stb,
    input  logic               vga_stb,
    input  soc_pkg::bus_req_t  req,
    input  logic               frame_start,
    output soc_pkg::bus_data_t rdata,
    output logic [15:0]        led,
    output soc_pkg::rgb_t      fg,
    output soc_pkg::rgb_t      bg,
    output logic               display_en,
    output logic               irq
);

    import soc_pkg::*;

    // Offset inside the VGA window
    logic [15:0] off;
    // Register write enables
    logic        wr_led;
    logic        wr_fg;
    logic        wr_bg;
    logic        wr_ctrl;
    logic        wr_status;
    // Ctrl bit 0 display enable, bit 1 irq enable
    logic [1:0]  ctrl_q;
    // Frame interrupt pending
    logic        status_q;
    // Combinational read select
    bus_data_t   rd_mux;

    assign off = req.addr[15:0];

    assign wr_led    = led_stb && req.we;
    assign wr_fg     = vga_stb && req.we && (off == `VGA_REG_FG);
    assign wr_bg     = vga_stb && req.we && (off == `VGA_REG_BG);
    assign wr_ctrl   = vga_stb && req.we && (off == `VGA_REG_CTRL);
    assign wr_status = vga_stb && req.we && (off == `VGA_REG_STATUS);

    // LED, colour and control registers
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led    <= '0;
            fg     <= '0;
            bg     <= '0;
            ctrl_q <= '0;
        end else begin
            if (wr_led) begin
                led <= req.wdata[15:0];
            end
            if (wr_fg) begin
                fg <= req.wdata[11:0];
            end
            if (wr_bg) begin
                bg <= req.wdata[11:0];
            end
            if (wr_ctrl) begin
                ctrl_q <= req.wdata[1:0];
            end
        end
    end

    // Frame interrupt latch
    // Set on frame start takes priority over a software clear
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= 1'b0;
        end else if (frame_start && ctrl_q[1]) begin
            status_q <= 1'b1;
        end else if (wr_status) begin
            status_q <= 1'b0;
        end
    end

    // Readback, zero-extended
    always_comb begin
        rd_mux = '0;
        if (led_stb) begin
            rd_mux = {16'h0000, led};
        end else if (vga_stb) begin
            case (off)
                `VGA_REG_FG:     rd_mux = {20'h00000, fg};
                `VGA_REG_BG:     rd_mux = {20'h00000, bg};
                `VGA_REG_CTRL:   rd_mux = {30'h00000000, ctrl_q};
                `VGA_REG_STATUS: rd_mux = {31'h00000000, status_q};
                // Holes in the window read zero
                default:         rd_mux = '0;
            endcase
        end
    end

    // One cycle read latency, same as the RAM
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_mux;
        end
    end

    assign display_en = ctrl_q[0];
    // Level output, masked by the enable bit
    assign irq        = status_q & ctrl_q[1];

endmodule

/* design/vga_timing.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module vga_timing #(
    parameter int H_ACTIVE = `H_ACTIVE,
    parameter int H_FRONT  = `H_FRONT,
    parameter int H_SYNC   = `H_SYNC,
    parameter int H_BACK   = `H_BACK,
    parameter int V_ACTIVE = `V_ACTIVE,
    parameter int V_FRONT  = `V_FRONT,
    parameter int V_SYNC   = `V_SYNC,
    parameter int V_BACK   = `V_BACK
) (
    input  logic              sys_clk,
    input  logic              arst_n,
    output soc_pkg::pix_pos_t x,
    output soc_pkg::pix_pos_t y,
    output logic              active,
    output logic              hsync,
    output logic              vsync,
    output logic              frame_start
);

    import soc_pkg::*;

    // Window edges in counter units
    localparam pix_pos_t H_ACT    = pix_pos_t'(H_ACTIVE);
    localparam pix_pos_t HS_START = pix_pos_t'(H_ACTIVE + H_FRONT);
    localparam pix_pos_t HS_END   = pix_pos_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam pix_pos_t H_LAST   = pix_pos_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam pix_pos_t V_ACT    = pix_pos_t'(V_ACTIVE);
    localparam pix_pos_t VS_START = pix_pos_t'(V_ACTIVE + V_FRONT);
    localparam pix_pos_t VS_END   = pix_pos_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam pix_pos_t V_LAST   = pix_pos_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    // Pixel within line, line within frame
    pix_pos_t h_cnt;
    pix_pos_t v_cnt;

    // One pixel per clock
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            // Line wrap steps the line counter
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign x = h_cnt;
    assign y = v_cnt;

    // Visible area
    assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);

    // Syncs are active low
    assign hsync = !((h_cnt >= HS_START) && (h_cnt < HS_END));
    assign vsync = !((v_cnt >= VS_START) && (v_cnt < VS_END));

    // Pulse on the first pixel of the frame
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // Horizontal sync pulse must sit in blanking
    a_hsync_blank: assert property (
        @(posedge sys_clk) disable iff (!arst_n)
        active |-> hsync
    );

endmodule

/* design/vga_pixel.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module vga_pixel #(
    parameter int CELL_LOG2 = `CELL_LOG2
) (
    input  logic              sys_clk,
    input  logic              arst_n,
    input  soc_pkg::pix_pos_t x,
    input  soc_pkg::pix_pos_t y,
    input  logic              active,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  soc_pkg::rgb_t     fg,
    input  soc_pkg::rgb_t     bg,
    input  logic              display_en,
    output soc_pkg::rgb_t     rgb,
    output logic              hsync,
    output logic              vsync
);

    import soc_pkg::*;

    // Odd checker cell
    logic cell_odd;
    // Colour before the output register
    rgb_t pix_colour;

    assign cell_odd = x[CELL_LOG2] ^ y[CELL_LOG2];

    // Checker colour, blanked outside the visible area
    always_comb begin
        if (active && display_en) begin
            pix_colour = cell_odd ? fg : bg;
        end else begin
            pix_colour = '0;
        end
    end

    // Colour and syncs share one stage
    // so all pins lag the counters by the same clock
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb   <= '0;
            // Syncs idle high
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= pix_colour;
            hsync <= hsync_in;
            vsync <= vsync_in;
        end
    end

endmodule

/* design/soc_top.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module soc_top #(
    parameter int H_ACTIVE  = `H_ACTIVE,
    parameter int H_FRONT   = `H_FRONT,
    parameter int H_SYNC    = `H_SYNC,
    parameter int H_BACK    = `H_BACK,
    parameter int V_ACTIVE  = `V_ACTIVE,
    parameter int V_FRONT   = `V_FRONT,
    parameter int V_SYNC    = `V_SYNC,
    parameter int V_BACK    = `V_BACK,
    parameter int CELL_LOG2 = `CELL_LOG2
) (
    input  logic               sys_clk,
    input  logic               arst_n,
    input  soc_pkg::bus_req_t  bus_req,
    output soc_pkg::bus_data_t bus_rdata,
    output logic [15:0]        led,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output soc_pkg::rgb_t      vga_rgb,
    output logic               irq
);

    import soc_pkg::*;

    // Region strobes
    dev_sel_t  sel;
    // Registered read data from each side
    bus_data_t ram_rdata;
    bus_data_t io_rdata;
    // Display settings
    rgb_t      fg;
    rgb_t      bg;
    logic      display_en;
    // Raster from the counters
    pix_pos_t  pix_x;
    pix_pos_t  pix_y;
    logic      pix_active;
    logic      raw_hsync;
    logic      raw_vsync;
    logic      frame_start;

    bus_decoder u_decoder (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .addr      (bus_req.addr),
        .sel       (sel),
        .ram_rdata (ram_rdata),
        .io_rdata  (io_rdata),
        .rdata     (bus_rdata)
    );

    // Byte address to word index, upper bits alias
    ram_block #(
        .WORDS (`RAM_WORDS)
    ) u_ram (
        .sys_clk   (sys_clk),
        .stb       (sel.ram),
        .we        (bus_req.we),
        .word_addr (bus_req.addr[`RAM_AW+1:2]),
        .wdata     (bus_req.wdata),
        .rdata     (ram_rdata)
    );

    io_regs u_io (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .led_stb     (sel.led),
        .vga_stb     (sel.vga),
        .req         (bus_req),
        .frame_start (frame_start),
        .rdata       (io_rdata),
        .led         (led),
        .fg          (fg),
        .bg          (bg),
        .display_en  (display_en),
        .irq         (irq)
    );

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .x           (pix_x),
        .y           (pix_y),
        .active      (pix_active),
        .hsync       (raw_hsync),
        .vsync       (raw_vsync),
        .frame_start (frame_start)
    );

    // Output stage, one clock behind the counters
    vga_pixel #(
        .CELL_LOG2 (CELL_LOG2)
    ) u_pixel (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .x          (pix_x),
        .y          (pix_y),
        .active     (pix_active),
        .hsync_in   (raw_hsync),
        .vsync_in   (raw_vsync),
        .fg         (fg),
        .bg         (bg),
        .display_en (display_en),
        .rgb        (vga_rgb),
        .hsync      (vga_hsync),
        .vsync      (vga_vsync)
    );

endmodule

/* bench/soc_tb.sv */
`timescale 1ns/1ps

`include "soc_settings.svh"

module soc_tb;

    import soc_pkg::*;

    // Short raster for simulation
    localparam int TB_H_ACTIVE  = 8;
    localparam int TB_H_FRONT   = 2;
    localparam int TB_H_SYNC    = 2;
    localparam int TB_H_BACK    = 2;
    localparam int TB_V_ACTIVE  = 4;
    localparam int TB_V_FRONT   = 1;
    localparam int TB_V_SYNC    = 1;
    localparam int TB_V_BACK    = 1;
    localparam int TB_CELL_LOG2 = 1;

    localparam int H_PERIOD     = TB_H_ACTIVE + TB_H_FRONT + TB_H_SYNC + TB_H_BACK;
    localparam int V_LINES      = TB_V_ACTIVE + TB_V_FRONT + TB_V_SYNC + TB_V_BACK;
    localparam int FRAME_CYCLES = H_PERIOD * V_LINES;
    // Pixel and line where each sync pulse begins
    localparam int H_SYNC_AT    = TB_H_ACTIVE + TB_H_FRONT;
    localparam int V_SYNC_AT    = TB_V_ACTIVE + TB_V_FRONT;
    // Long enough to catch two vsync pulses from any start point
    localparam int WATCH_CYCLES = 2 * FRAME_CYCLES + H_PERIOD;
    localparam int RESET_CYCLES = 8;

    localparam rgb_t      FG_COLOUR   = 12'h0A5;
    localparam rgb_t      BG_COLOUR   = 12'hF3C;
    localparam bus_addr_t FG_ADDR     = {`VGA_BASE_HI, `VGA_REG_FG};
    localparam bus_addr_t BG_ADDR     = {`VGA_BASE_HI, `VGA_REG_BG};
    localparam bus_addr_t CTRL_ADDR   = {`VGA_BASE_HI, `VGA_REG_CTRL};
    localparam bus_addr_t STATUS_ADDR = {`VGA_BASE_HI, `VGA_REG_STATUS};

    // One bus access and its expected read value
    typedef struct packed {
        logic      we;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_data_t exp;
    } access_t;

    logic        sys_clk;
    logic        arst_n;
    bus_req_t    bus_req;
    bus_data_t   bus_rdata;
    logic [15:0] led;
    logic        vga_hsync;
    logic        vga_vsync;
    rgb_t        vga_rgb;
    logic        irq;

    access_t     table_q[$];
    // Reference RAM, indexed by word-address bits
    bus_data_t   ram_model [`RAM_WORDS];
    logic [15:0] led_model;
    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          mark;
    int          cycle_count;
    int          cycle_limit = 100000;

    soc_top #(
        .H_ACTIVE  (TB_H_ACTIVE),
        .H_FRONT   (TB_H_FRONT),
        .H_SYNC    (TB_H_SYNC),
        .H_BACK    (TB_H_BACK),
        .V_ACTIVE  (TB_V_ACTIVE),
        .V_FRONT   (TB_V_FRONT),
        .V_SYNC    (TB_V_SYNC),
        .V_BACK    (TB_V_BACK),
        .CELL_LOG2 (TB_CELL_LOG2)
    ) UUT (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .led       (led),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_rgb   (vga_rgb),
        .irq       (irq)
    );

    // 20 ns period
    always #10 sys_clk = ~sys_clk;

    // Run limit
    always @(posedge sys_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic bus_data_t rand_word();
        return $random(seed);
    endfunction

    // Region rule: LED word, VGA window, RAM for the rest
    function automatic bit is_ram_addr(input bus_addr_t addr);
        return (addr != `LED_ADDR) && (addr[31:16] != `VGA_BASE_HI);
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", sig, got, want, $time);
        errors = errors + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s at %0t", what, $time);
        errors = errors + 1;
    endtask

    task automatic end_test(input string name, input int err_at_start);
        int n;
        n = errors - err_at_start;
        tests_run = tests_run + 1;
        if (n != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %s finished with %0d errors", name, n);
    endtask

    task automatic add_access(input logic we, input bus_addr_t addr,
                              input bus_data_t wdata, input bus_data_t exp);
        access_t a;
        a.we    = we;
        a.addr  = addr;
        a.wdata = wdata;
        a.exp   = exp;
        table_q.push_back(a);
    endtask

    // RAM read values come from the model, so their exp is zero here
    task automatic build_table();
        // Distinct words, two of them just outside the VGA window
        add_access(1'b1, 32'h0000_0010, rand_word(), '0);
        add_access(1'b1, 32'h0000_0004, rand_word(), '0);
        add_access(1'b1, 32'h0000_0FF8, rand_word(), '0);
        add_access(1'b1, 32'hAAA9_FFFC, rand_word(), '0);
        add_access(1'b1, 32'hAAAB_0000, rand_word(), '0);
        add_access(1'b0, 32'h0000_0010, '0, '0);
        add_access(1'b0, 32'h0000_0004, '0, '0);
        add_access(1'b0, 32'h0000_0FF8, '0, '0);
        add_access(1'b0, 32'hAAA9_FFFC, '0, '0);
        add_access(1'b0, 32'hAAAB_0000, '0, '0);
        // Same word index as 0x0004
        add_access(1'b1, 32'h0000_1004, rand_word(), '0);
        add_access(1'b0, 32'h0000_0004, '0, '0);
        add_access(1'b0, 32'h0000_1004, '0, '0);
        // LED, upper half dropped
        add_access(1'b1, `LED_ADDR, 32'h1234_BEEF, '0);
        add_access(1'b0, `LED_ADDR, '0, 32'h0000_BEEF);
        // Colour registers keep 12 bits, ctrl keeps 2
        add_access(1'b1, FG_ADDR, {20'hFFFFF, FG_COLOUR}, '0);
        add_access(1'b1, BG_ADDR, {20'h00000, BG_COLOUR}, '0);
        add_access(1'b1, CTRL_ADDR, 32'hFFFF_FFF1, '0);
        add_access(1'b0, FG_ADDR, '0, {20'h00000, FG_COLOUR});
        add_access(1'b0, BG_ADDR, '0, {20'h00000, BG_COLOUR});
        add_access(1'b0, CTRL_ADDR, '0, 32'h0000_0001);
        add_access(1'b0, STATUS_ADDR, '0, 32'h0000_0000);
        // Holes in the window
        add_access(1'b0, 32'hAAAA_0010, '0, 32'h0000_0000);
        add_access(1'b0, 32'hAAAA_FFF0, '0, 32'h0000_0000);
        // Writes elsewhere leave the LEDs alone
        add_access(1'b1, 32'h0000_0008, rand_word(), '0);
        add_access(1'b1, 32'hAAAA_0020, 32'hFFFF_FFFF, '0);
        add_access(1'b0, 32'h0000_0008, '0, '0);
        add_access(1'b0, `LED_ADDR, '0, 32'h0000_BEEF);
    endtask

    // Starts and ends on a falling edge
    task automatic run_table();
        access_t              a;
        bus_data_t            want;
        logic [`RAM_AW-1:0]   idx;
        foreach (table_q[i]) begin
            a             = table_q[i];
            idx           = a.addr[`RAM_AW+1:2];
            bus_req.we    = a.we;
            bus_req.addr  = a.addr;
            bus_req.wdata = a.wdata;
            if (is_ram_addr(a.addr)) begin
                if (a.we) begin
                    ram_model[idx] = a.wdata;
                end
                want = ram_model[idx];
            end else begin
                if (a.we && a.addr == `LED_ADDR) begin
                    led_model = a.wdata[15:0];
                end
                want = a.exp;
            end
            @(negedge sys_clk);
            if (!a.we && bus_rdata !== want) begin
                report_mismatch("bus_rdata", bus_rdata, want);
            end
            if (led !== led_model) begin
                report_mismatch("led", led, led_model);
            end
        end
        bus_req = '0;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_req.we    = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        @(negedge sys_clk);
        bus_req = '0;
    endtask

    // Tracks the raster position from the sync edges and checks every pixel
    task automatic watch_raster(input logic disp_on);
        int   h_pos;
        int   v_pos;
        bit   h_known;
        bit   v_known;
        logic hs_prev;
        logic vs_prev;
        int   hs_fall_at;
        int   vs_fall_at;
        int   hs_low;
        int   vs_low;
        int   n_vs_fall;
        bit   on_pixel;
        rgb_t want;
        h_pos      = 0;
        v_pos      = 0;
        h_known    = 1'b0;
        v_known    = 1'b0;
        hs_prev    = vga_hsync;
        vs_prev    = vga_vsync;
        hs_fall_at = -1;
        vs_fall_at = -1;
        hs_low     = 0;
        vs_low     = 0;
        n_vs_fall  = 0;
        for (int i = 0; i < WATCH_CYCLES; i++) begin
            @(negedge sys_clk);
            // One pixel per clock
            h_pos = (h_pos + 1) % H_PERIOD;
            if (h_pos == 0) begin
                v_pos = (v_pos + 1) % V_LINES;
            end
            if (hs_prev && !vga_hsync) begin
                if (hs_fall_at >= 0 && i - hs_fall_at != H_PERIOD) begin
                    report_mismatch("vga_hsync period", i - hs_fall_at, H_PERIOD);
                end
                hs_fall_at = i;
                hs_low     = 0;
                h_pos      = H_SYNC_AT;
                h_known    = 1'b1;
            end
            if (!hs_prev && vga_hsync && hs_fall_at >= 0 && hs_low != TB_H_SYNC) begin
                report_mismatch("vga_hsync low clocks", hs_low, TB_H_SYNC);
            end
            if (!vga_hsync) begin
                hs_low = hs_low + 1;
            end
            // Vsync drops on the first pixel of a line
            if (vs_prev && !vga_vsync) begin
                if (vs_fall_at >= 0 && i - vs_fall_at != FRAME_CYCLES) begin
                    report_mismatch("vga_vsync period", i - vs_fall_at, FRAME_CYCLES);
                end
                if (h_known && h_pos != 0) begin
                    report_mismatch("vga_vsync edge pixel", h_pos, 0);
                end
                vs_fall_at = i;
                vs_low     = 0;
                n_vs_fall  = n_vs_fall + 1;
                v_pos      = V_SYNC_AT;
                v_known    = 1'b1;
            end
            if (!vs_prev && vga_vsync && vs_fall_at >= 0 && vs_low != TB_V_SYNC * H_PERIOD) begin
                report_mismatch("vga_vsync low clocks", vs_low, TB_V_SYNC * H_PERIOD);
            end
            if (!vga_vsync) begin
                vs_low = vs_low + 1;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
            // Checker rule, zero in blanking
            if (h_known && v_known) begin
                on_pixel = (h_pos < TB_H_ACTIVE) && (v_pos < TB_V_ACTIVE);
                if (!disp_on || !on_pixel) begin
                    want = '0;
                end else if ((((h_pos >> TB_CELL_LOG2) ^ (v_pos >> TB_CELL_LOG2)) & 1) == 1) begin
                    want = FG_COLOUR;
                end else begin
                    want = BG_COLOUR;
                end
                if (vga_rgb !== want) begin
                    report_mismatch("vga_rgb", vga_rgb, want);
                end
            end
            // Interrupt enable is off while the raster is watched
            if (irq !== 1'b0) begin
                report_mismatch("irq", irq, 0);
            end
        end
        if (n_vs_fall < 2 || hs_fall_at < 0) begin
            report_failure("fewer than two vsync pulses or no hsync pulse in the window");
        end
    endtask

    task automatic wait_irq_rise();
        int waited;
        for (waited = 0; irq !== 1'b1 && waited <= FRAME_CYCLES; waited++) begin
            @(negedge sys_clk);
        end
        if (irq !== 1'b1) begin
            report_failure("irq did not rise within one frame period");
        end
    endtask

    task automatic check_irq_level(input logic level, input int n_cycles);
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge sys_clk);
            if (irq !== level) begin
                report_mismatch("irq", irq, level);
            end
        end
    endtask

    initial begin
        sys_clk      = 1'b0;
        arst_n       = 1'b0;
        bus_req      = '0;
        seed         = 32'hb0760004;
        led_model    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        build_table();
        cycle_limit  = RESET_CYCLES + table_q.size() + 2 * WATCH_CYCLES
                       + 4 * FRAME_CYCLES + 64;

        // Outputs idle during reset
        mark = errors;
        repeat (RESET_CYCLES) @(negedge sys_clk);
        if (bus_rdata !== '0) begin
            report_mismatch("bus_rdata", bus_rdata, 0);
        end
        if (led !== '0) begin
            report_mismatch("led", led, 0);
        end
        if (irq !== 1'b0) begin
            report_mismatch("irq", irq, 0);
        end
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1) begin
            report_mismatch("vga_hsync/vga_vsync", {vga_hsync, vga_vsync}, 2'b11);
        end
        if (vga_rgb !== '0) begin
            report_mismatch("vga_rgb", vga_rgb, 0);
        end
        arst_n = 1'b1;
        end_test("reset", mark);

        mark = errors;
        run_table();
        end_test("bus_table", mark);

        // Display was enabled by the table
        mark = errors;
        watch_raster(1'b1);
        end_test("raster_enabled", mark);

        mark = errors;
        bus_write(CTRL_ADDR, 32'h0000_0000);
        watch_raster(1'b0);
        end_test("raster_disabled", mark);

        // Set, hold, clear, set again, then masked
        mark = errors;
        bus_write(CTRL_ADDR, 32'h0000_0003);
        wait_irq_rise();
        check_irq_level(1'b1, 20);
        bus_write(STATUS_ADDR, 32'h0000_0000);
        if (irq !== 1'b0) begin
            report_mismatch("irq", irq, 0);
        end
        wait_irq_rise();
        bus_write(CTRL_ADDR, 32'h0000_0001);
        if (irq !== 1'b0) begin
            report_mismatch("irq", irq, 0);
        end
        bus_write(STATUS_ADDR, 32'h0000_0000);
        check_irq_level(1'b0, FRAME_CYCLES + H_PERIOD);
        end_test("interrupt", mark);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/soc_pkg.sv
design/bus_decoder.sv
design/ram_block.sv
design/io_regs.sv
design/vga_timing.sv
design/vga_pixel.sv
design/soc_top.sv
bench/soc_tb.sv

/* Bender.yml */
package:
  name: soc_periph

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/bus_decoder.sv
      - design/ram_block.sv
      - design/io_regs.sv
      - design/vga_timing.sv
      - design/vga_pixel.sv
      - design/soc_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/soc_tb.sv
